/* tb.f */
+incdir+sim
src/trap_pkg.sv
src/csr_file.sv
src/irq_arbiter.sv
src/machine_timer.sv
src/trap_ctrl.sv
src/trap_unit.sv
sim/trap_unit_tb.sv

/* sim/trap_ref.svh */
// Testbench helpers: xorshift generator, reference model functions, typed compare tasks.
`ifndef trap_ref_svh
`define trap_ref_svh

// Next xorshift32 state.
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Expected read value of a CSR after writing w to it.
function automatic logic [31:0] ref_csr_read(input trap_pkg::csr_addr_t addr,
                                             input logic [31:0] w);
    case (addr)
        trap_pkg::csr_mtvec:   return w & 32'hffff_fffc;
        trap_pkg::csr_mepc:    return w & 32'hffff_fffe;
        trap_pkg::csr_marchid: return 32'd37;
        trap_pkg::csr_mhartid: return 32'd5;
        trap_pkg::csr_medeleg, trap_pkg::csr_mideleg, trap_pkg::csr_mtval: return 32'd0;
        default:               return w;
    endcase
endfunction

// mstatus after a write; MPP is M or U only.
function automatic logic [31:0] ref_status_write(input logic [31:0] w);
    logic [31:0] r;
    r = '0;
    r[3] = w[3];
    r[7] = w[7];
    r[17] = w[17];
    r[12:11] = (w[12:11] != 2'd0) ? 2'd3 : 2'd0;
    return r;
endfunction

// mstatus after a trap taken in privilege p.
function automatic logic [31:0] ref_status_trap(input logic [31:0] st, input logic [1:0] p);
    logic [31:0] r;
    r = st;
    r[7] = st[3];
    r[3] = 1'b0;
    r[12:11] = p;
    return r;
endfunction

// mstatus after MRET; leaving M clears MPRV.
function automatic logic [31:0] ref_status_ret(input logic [31:0] st);
    logic [31:0] r;
    r = st;
    r[3] = st[7];
    if (st[12:11] != 2'd3) begin
        r[17] = 1'b0;
    end
    return r;
endfunction

// Lowest pending and enabled interrupt.
function automatic trap_pkg::cause_t ref_irq_cause(input logic [31:0] pend, input logic [31:0] en);
    logic [31:0] m;
    m = pend & en;
    for (int i = 0; i < 32; i++) begin
        if (m[i]) begin
            return trap_pkg::cause_t'(i);
        end
    end
    return '0;
endfunction

task automatic check_word(input string name, input logic [trap_pkg::xlen-1:0] got,
                          input logic [trap_pkg::xlen-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_priv(input string name, input trap_pkg::priv_t got,
                          input trap_pkg::priv_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_cause(input string name, input trap_pkg::cause_t got,
                           input trap_pkg::cause_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
endtask

`endif

/* sim/trap_unit_tb.sv */
// Testbench top with clock, reset, CSR, trap, interrupt, timer and privilege tests.
`default_nettype none
`timescale 1ns/1ps

module trap_unit_tb;
    localparam logic [31:0] base = 32'h0200_0000;
    // Cycle budget of the five tests plus reset and margin.
    localparam int test_cycles = 40 + 40 + 50 + 260 + 50;
    localparam int limit_ns = (5 + test_cycles + 100) * 4;

    logic clk, rst, csr_we, csr_exists, csr_rdonly;
    trap_pkg::csr_addr_t csr_addr;
    logic [31:0] csr_wdata, csr_rdata;
    logic mmio_we, mmio_hit;
    logic [31:0] mmio_addr, mmio_wdata, mmio_rdata;
    logic retire_valid, retire_trap, retire_ret;
    logic [31:0] retire_pc;
    trap_pkg::cause_t retire_cause, trap_cause;
    logic [31:16] irq;
    logic trap_taken, trap_irq, ret_taken;
    logic [31:0] trap_vector, ret_epc;
    trap_pkg::priv_t cur_priv;

    // Expected outcome of the current retire.
    logic chk_en, exp_taken, exp_irq, exp_ret;
    trap_pkg::cause_t exp_cause;
    logic [31:0] exp_vector, exp_epc;
    // Architectural model.
    logic [31:0] model_status, model_mtvec, model_mepc, model_mcause;
    trap_pkg::priv_t model_priv;
    logic [31:0] seed;
    int checks, errors, test_no, test_errs;

    `include "trap_ref.svh"

    trap_unit #(.hartid(32'd5), .has_u_mode(1'b1), .mmio_base(base)) i_trap_unit (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(limit_ns);
        $display("timeout: tests did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

    // Retire outcome sampled mid-cycle.
    always @(negedge clk) begin
        if (chk_en) begin
            check_word("trap_taken", {31'd0, trap_taken}, {31'd0, exp_taken});
            check_word("trap_irq", {31'd0, trap_irq}, {31'd0, exp_irq});
            check_word("ret_taken", {31'd0, ret_taken}, {31'd0, exp_ret});
            if (exp_taken) begin
                check_cause("trap_cause", trap_cause, exp_cause);
                check_word("trap_vector", trap_vector, exp_vector);
            end
            if (exp_ret) begin
                check_word("ret_epc", ret_epc, exp_epc);
            end
        end
    end

    task automatic csr_write(input trap_pkg::csr_addr_t a, input logic [31:0] d);
        @(posedge clk);
        csr_we <= 1'b1;
        csr_addr <= a;
        csr_wdata <= d;
        @(posedge clk);
        csr_we <= 1'b0;
        case (a)
            trap_pkg::csr_mstatus: model_status = ref_status_write(d);
            trap_pkg::csr_mtvec:   model_mtvec = ref_csr_read(a, d);
            trap_pkg::csr_mepc:    model_mepc = ref_csr_read(a, d);
            default: ;
        endcase
    endtask

    task automatic csr_read(input trap_pkg::csr_addr_t a, output logic [31:0] d);
        @(posedge clk);
        csr_addr <= a;
        @(negedge clk);
        d = csr_rdata;
    endtask

    task automatic mmio_write(input logic [31:0] off, input logic [31:0] d);
        @(posedge clk);
        mmio_we <= 1'b1;
        mmio_addr <= base + off;
        mmio_wdata <= d;
        @(posedge clk);
        mmio_we <= 1'b0;
    endtask

    task automatic mmio_read(input logic [31:0] off, output logic [31:0] d);
        @(posedge clk);
        mmio_addr <= base + off;
        @(negedge clk);
        d = mmio_rdata;
    endtask

    // One retire; the model moves to the expected state.
    task automatic retire_check(input logic [31:0] pc, input logic trap, input logic ret,
                                input logic want_irq, input trap_pkg::cause_t c);
        exp_irq = want_irq;
        exp_taken = want_irq || trap;
        exp_ret = ret && !exp_taken;
        exp_cause = c;
        exp_vector = model_mtvec;
        exp_epc = model_mepc;
        @(posedge clk);
        retire_valid <= 1'b1;
        retire_pc <= pc;
        retire_trap <= trap;
        retire_ret <= ret;
        retire_cause <= c;
        chk_en = 1'b1;
        @(posedge clk);
        retire_valid <= 1'b0;
        retire_trap <= 1'b0;
        retire_ret <= 1'b0;
        chk_en = 1'b0;
        if (exp_taken) begin
            model_status = ref_status_trap(model_status, model_priv);
            model_priv = trap_pkg::priv_m;
            model_mepc = pc & 32'hffff_fffe;
            model_mcause = {want_irq, 26'd0, c};
        end else if (exp_ret) begin
            model_priv = (model_status[12:11] == 2'd0) ? trap_pkg::priv_u : trap_pkg::priv_m;
            model_status = ref_status_ret(model_status);
        end
    endtask

    task automatic check_state();
        logic [31:0] v;
        csr_read(trap_pkg::csr_mstatus, v);
        check_word("mstatus", v, model_status);
        csr_read(trap_pkg::csr_mepc, v);
        check_word("mepc", v, model_mepc);
        csr_read(trap_pkg::csr_mcause, v);
        check_word("mcause", v, model_mcause);
        check_priv("cur_priv", cur_priv, model_priv);
    endtask

    task automatic end_test(input string name);
        test_no++;
        $display("test %0d %s: %s, %0d errors", test_no, name,
                 (errors == test_errs) ? "ok" : "wrong", errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        trap_pkg::csr_addr_t csr_list[6];
        logic [31:0] w, v, lines, mask, now, cmp;
        int n;
        csr_list = '{trap_pkg::csr_mscratch, trap_pkg::csr_mie, trap_pkg::csr_mtvec,
                     trap_pkg::csr_marchid, trap_pkg::csr_mhartid, trap_pkg::csr_medeleg};
        rst = 1'b1;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        mmio_we = 1'b0;
        mmio_addr = '0;
        mmio_wdata = '0;
        retire_valid = 1'b0;
        retire_pc = '0;
        retire_trap = 1'b0;
        retire_ret = 1'b0;
        retire_cause = '0;
        irq = '0;
        chk_en = 1'b0;
        seed = 32'h8a49_f9a1;
        checks = 0;
        errors = 0;
        test_no = 0;
        test_errs = 0;
        // Reset state has MPP at M and all else zero.
        model_status = 32'h0000_1800;
        model_mtvec = '0;
        model_mepc = '0;
        model_mcause = '0;
        model_priv = trap_pkg::priv_m;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Writable words before fixed ones and an unlisted address.
        for (int i = 0; i < 6; i++) begin
            seed = xorshift32(seed);
            w = seed;
            if (i < 3) begin
                csr_write(csr_list[i], w);
            end
            csr_read(csr_list[i], v);
            check_word($sformatf("csr %h", csr_list[i]), v, ref_csr_read(csr_list[i], w));
            check_word("csr_exists", {31'd0, csr_exists}, 32'd1);
            // Addresses 0xfxx are the read-only ID space.
            check_word("csr_rdonly", {31'd0, csr_rdonly},
                       (csr_list[i][11:10] == 2'b11) ? 32'd1 : 32'd0);
        end
        csr_read(12'h7c0, v);
        check_word("csr_exists", {31'd0, csr_exists}, 32'd0);
        end_test("csr access");

        // Synchronous trap from M with MIE set.
        csr_write(trap_pkg::csr_mie, 32'd0);
        csr_write(trap_pkg::csr_mstatus, 32'h0000_1808);
        seed = xorshift32(seed);
        retire_check(seed, 1'b1, 1'b0, 1'b0, seed[4:0]);
        check_state();
        end_test("sync trap");

        // External lines with a random enable mask.
        seed = xorshift32(seed);
        mask = seed & 32'hffff_0000;
        if (mask == 32'd0) begin
            mask = 32'h0001_0000;
        end
        seed = xorshift32(seed);
        lines = seed & 32'hffff_0000;
        if ((lines & mask) == 32'd0) begin
            lines = lines | (mask & (~mask + 32'd1));
        end
        csr_write(trap_pkg::csr_mie, mask);
        @(posedge clk);
        irq <= lines[31:16];
        csr_write(trap_pkg::csr_mstatus, 32'h0000_1808);
        repeat (4) @(posedge clk);
        csr_read(trap_pkg::csr_mip, v);
        check_word("mip", v, lines & mask);
        seed = xorshift32(seed);
        retire_check(seed, 1'b0, 1'b0, 1'b1, ref_irq_cause(lines, mask));
        check_state();
        @(posedge clk);
        irq <= '0;
        csr_write(trap_pkg::csr_mie, 32'd0);
        end_test("external irq");

        // Timer fires a little after the current mtime.
        mmio_read(32'd0, now);
        cmp = now + 32'd16;
        mmio_write(32'd12, 32'd0);
        mmio_write(32'd8, cmp);
        // mtimecmp reads back and an address past the block misses.
        mmio_read(32'd8, v);
        check_word("mtimecmp low", v, cmp);
        check_word("mmio_hit", {31'd0, mmio_hit}, 32'd1);
        mmio_read(32'd12, v);
        check_word("mtimecmp high", v, 32'd0);
        mmio_read(32'd16, v);
        check_word("mmio_hit", {31'd0, mmio_hit}, 32'd0);
        csr_write(trap_pkg::csr_mie, 32'h0000_0080);
        csr_write(trap_pkg::csr_mstatus, 32'h0000_1808);
        n = 0;
        mmio_read(32'd0, now);
        while (now <= cmp && n < 100) begin
            mmio_read(32'd0, now);
            n++;
        end
        if (now <= cmp) begin
            errors++;
            $display("timeout: mtime never passed mtimecmp");
        end
        // Compare register and latch stage.
        repeat (2) @(posedge clk);
        seed = xorshift32(seed);
        retire_check(seed, 1'b0, 1'b0, 1'b1, trap_pkg::irq_timer);
        check_state();
        mmio_write(32'd12, 32'hffff_ffff);
        mmio_write(32'd8, 32'hffff_ffff);
        csr_write(trap_pkg::csr_mstatus, 32'h0000_1808);
        repeat (4) @(posedge clk);
        retire_check(seed, 1'b0, 1'b0, 1'b0, '0);
        csr_write(trap_pkg::csr_mie, 32'd0);
        end_test("timer irq");

        // MRET to U and a trap back to M.
        csr_write(trap_pkg::csr_mstatus, 32'h0000_0080);
        seed = xorshift32(seed);
        csr_write(trap_pkg::csr_mepc, seed);
        seed = xorshift32(seed);
        retire_check(seed, 1'b0, 1'b1, 1'b0, '0);
        check_state();
        check_priv("cur_priv after mret", cur_priv, trap_pkg::priv_u);
        seed = xorshift32(seed);
        retire_check(seed, 1'b1, 1'b0, 1'b0, seed[4:0]);
        check_state();
        csr_read(trap_pkg::csr_mstatus, v);
        check_priv("mstatus.mpp", v[12:11], trap_pkg::priv_u);
        end_test("privilege");

        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/trap_unit.sv */
// Module trap_unit: top level joining CSR file, interrupt arbiter, timer and trap control.
`default_nettype none
`timescale 1ns/1ps

module trap_unit #(
    parameter logic [31:0] hartid     = 32'h0,
    parameter bit          has_u_mode = 1'b1,
    parameter logic [31:0] mmio_base  = 32'hff00_0000
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       csr_we,
    input  wire trap_pkg::csr_addr_t        csr_addr,
    input  wire logic [trap_pkg::xlen-1:0]  csr_wdata,
    output      logic [trap_pkg::xlen-1:0]  csr_rdata,
    output      logic                       csr_exists,
    output      logic                       csr_rdonly,
    input  wire logic                       mmio_we,
    input  wire logic [trap_pkg::xlen-1:0]  mmio_addr,
    input  wire logic [trap_pkg::xlen-1:0]  mmio_wdata,
    output      logic [trap_pkg::xlen-1:0]  mmio_rdata,
    output      logic                       mmio_hit,
    input  wire logic                       retire_valid,
    input  wire logic [trap_pkg::xlen-1:0]  retire_pc,
    input  wire logic                       retire_trap,
    input  wire trap_pkg::cause_t           retire_cause,
    input  wire logic                       retire_ret,
    input  wire logic [31:16]               irq,
    output      logic                       trap_taken,
    output      logic                       trap_irq,
    output      trap_pkg::cause_t           trap_cause,
    output      logic [trap_pkg::xlen-1:0]  trap_vector,
    output      logic                       ret_taken,
    output      logic [trap_pkg::xlen-1:0]  ret_epc,
    output      trap_pkg::priv_t            cur_priv
);
    logic                      ex_trap, ex_irq, ex_ret;
    trap_pkg::cause_t          ex_cause;
    logic [31:1]               ex_epc;
    logic [trap_pkg::xlen-1:0] mie_reg, ip_latched;
    logic                      status_mie, timer_irq, irq_pending;
    logic [31:2]               mtvec;
    logic [31:1]               mepc;
    trap_pkg::priv_t           mpp;
    trap_pkg::cause_t          irq_cause;

    csr_file #(.hartid(hartid), .has_u_mode(has_u_mode)) i_csr_file (
        .clk(clk), .rst(rst), .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_rdonly(csr_rdonly),
        .ex_trap(ex_trap), .ex_irq(ex_irq), .ex_cause(ex_cause), .ex_epc(ex_epc),
        .ex_ret(ex_ret), .cur_priv(cur_priv), .ip_latched(ip_latched), .mie_reg(mie_reg),
        .status_mie(status_mie), .mtvec(mtvec), .mepc(mepc), .mpp(mpp)
    );

    irq_arbiter i_irq_arbiter (
        .clk(clk), .rst(rst), .irq(irq), .timer_irq(timer_irq), .mie_reg(mie_reg),
        .status_mie(status_mie), .ip_latched(ip_latched), .irq_pending(irq_pending),
        .irq_cause(irq_cause)
    );

    machine_timer #(.mmio_base(mmio_base)) i_machine_timer (
        .clk(clk), .rst(rst), .mmio_we(mmio_we), .mmio_addr(mmio_addr),
        .mmio_wdata(mmio_wdata), .mmio_rdata(mmio_rdata), .mmio_hit(mmio_hit),
        .timer_irq(timer_irq)
    );

    trap_ctrl #(.has_u_mode(has_u_mode)) i_trap_ctrl (
        .clk(clk), .rst(rst), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_trap(retire_trap), .retire_cause(retire_cause), .retire_ret(retire_ret),
        .irq_pending(irq_pending), .irq_cause(irq_cause), .mtvec(mtvec), .mpp(mpp),
        .ex_trap(ex_trap), .ex_irq(ex_irq), .ex_cause(ex_cause), .ex_epc(ex_epc),
        .ex_ret(ex_ret), .cur_priv(cur_priv), .trap_vector(trap_vector)
    );

    // Result outputs.
    assign trap_taken = ex_trap || ex_irq;
    assign trap_irq   = ex_irq;
    assign trap_cause = ex_cause;
    assign ret_taken  = ex_ret;
    assign ret_epc    = {mepc, 1'b0};

endmodule

`default_nettype wire

/* src/trap_ctrl.sv */
// Module trap_ctrl: privilege-mode FSM and interrupt/trap/return selection.
`default_nettype none
`timescale 1ns/1ps

module trap_ctrl #(
    parameter bit has_u_mode = 1'b1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       retire_valid,
    input  wire logic [trap_pkg::xlen-1:0]  retire_pc,
    input  wire logic                       retire_trap,
    input  wire trap_pkg::cause_t           retire_cause,
    input  wire logic                       retire_ret,
    input  wire logic                       irq_pending,
    input  wire trap_pkg::cause_t           irq_cause,
    input  wire logic [31:2]                mtvec,
    input  wire trap_pkg::priv_t            mpp,
    output      logic                       ex_trap,
    output      logic                       ex_irq,
    output      trap_pkg::cause_t           ex_cause,
    output      logic [31:1]                ex_epc,
    output      logic                       ex_ret,
    output      trap_pkg::priv_t            cur_priv,
    output      logic [trap_pkg::xlen-1:0]  trap_vector
);
    // Interrupt beats trap, trap beats return.
    assign ex_irq   = retire_valid && irq_pending;
    assign ex_trap  = retire_valid && retire_trap && !ex_irq;
    assign ex_ret   = retire_valid && retire_ret && !retire_trap && !ex_irq;
    assign ex_cause = ex_irq ? irq_cause : retire_cause;
    assign ex_epc   = retire_pc[31:1];

    // Direct mode only.
    assign trap_vector = {mtvec, 2'b00};

    generate
        if (has_u_mode) begin : g_priv_u
            trap_pkg::priv_t priv_next;

            // M on any trap, MPP on return.
            always_comb begin
                priv_next = cur_priv;
                if (ex_trap || ex_irq) begin
                    priv_next = trap_pkg::priv_m;
                end else if (ex_ret) begin
                    priv_next = (mpp == trap_pkg::priv_u) ? trap_pkg::priv_u : trap_pkg::priv_m;
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    cur_priv <= trap_pkg::priv_m;
                end else begin
                    cur_priv <= priv_next;
                end
            end
        end else begin : g_priv_m
            // M-mode only.
            assign cur_priv = trap_pkg::priv_m;
        end
    endgenerate

endmodule

`default_nettype wire

/* src/machine_timer.sv */
// Module machine_timer: mtime and mtimecmp with MMIO decode and the timer interrupt.
`default_nettype none
`timescale 1ns/1ps

module machine_timer #(
    parameter logic [31:0] mmio_base = 32'hff00_0000
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       mmio_we,
    input  wire logic [trap_pkg::xlen-1:0]  mmio_addr,
    input  wire logic [trap_pkg::xlen-1:0]  mmio_wdata,
    output      logic [trap_pkg::xlen-1:0]  mmio_rdata,
    output      logic                       mmio_hit,
    output      logic                       timer_irq
);
    logic [63:0]               mtime;
    logic [63:0]               mtimecmp;
    logic [trap_pkg::xlen-1:0] offset;

    // Byte offset into the timer block.
    assign offset = mmio_addr - mmio_base;

    // Word decode and read mux.
    always_comb begin
        mmio_hit   = 1'b1;
        mmio_rdata = '0;
        case (offset)
            32'd0:   mmio_rdata = mtime[31:0];
            32'd4:   mmio_rdata = mtime[63:32];
            32'd8:   mmio_rdata = mtimecmp[31:0];
            32'd12:  mmio_rdata = mtimecmp[63:32];
            default: mmio_hit = 1'b0;
        endcase
    end

    // Counts every clk; a write replaces one half.
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (mmio_we) begin
                case (offset)
                    32'd0:   mtime[31:0]     <= mmio_wdata;
                    32'd4:   mtime[63:32]    <= mmio_wdata;
                    32'd8:   mtimecmp[31:0]  <= mmio_wdata;
                    32'd12:  mtimecmp[63:32] <= mmio_wdata;
                    default: ;
                endcase
            end
        end
    end

    // Registered compare.
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

endmodule

`default_nettype wire

/* src/irq_arbiter.sv */
// Module irq_arbiter: interrupt latching, mie masking, lowest-index priority, enable delay.
`default_nettype none
`timescale 1ns/1ps

module irq_arbiter (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [31:16]               irq,
    input  wire logic                       timer_irq,
    input  wire logic [trap_pkg::xlen-1:0]  mie_reg,
    input  wire logic                       status_mie,
    output      logic [trap_pkg::xlen-1:0]  ip_latched,
    output      logic                       irq_pending,
    output      trap_pkg::cause_t           irq_cause
);
    logic [trap_pkg::xlen-1:0] ip_next;
    logic [trap_pkg::xlen-1:0] masked;
    logic [1:0]                mie_hist;

    // Standard mip positions.
    always_comb begin
        ip_next                                  = '0;
        ip_next[31:trap_pkg::irq_ext_lo]         = irq;
        ip_next[trap_pkg::irq_timer]             = timer_irq;
    end

    // One register stage on all lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_latched <= '0;
        end else begin
            ip_latched <= ip_next;
        end
    end

    // MIE sampled at the last two edges.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= 2'b00;
        end else begin
            mie_hist <= {mie_hist[0], status_mie};
        end
    end

    assign masked = ip_latched & mie_reg;

    // Lowest set index wins.
    always_comb begin
        irq_cause = '0;
        for (int i = trap_pkg::xlen - 1; i >= 0; i--) begin
            if (masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    assign irq_pending = (masked != '0) && (&mie_hist);

endmodule

`default_nettype wire

/* src/csr_file.sv */
// Module csr_file: machine CSR storage, write decode, read mux and trap/return updates.
`default_nettype none
`timescale 1ns/1ps

module csr_file #(
    parameter logic [31:0] hartid = 32'h0,
    parameter bit has_u_mode = 1'b1
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       csr_we,
    input  wire trap_pkg::csr_addr_t        csr_addr,
    input  wire logic [trap_pkg::xlen-1:0]  csr_wdata,
    output      logic [trap_pkg::xlen-1:0]  csr_rdata,
    output      logic                       csr_exists,
    output      logic                       csr_rdonly,
    input  wire logic                       ex_trap,
    input  wire logic                       ex_irq,
    input  wire trap_pkg::cause_t           ex_cause,
    input  wire logic [31:1]                ex_epc,
    input  wire logic                       ex_ret,
    input  wire trap_pkg::priv_t            cur_priv,
    input  wire logic [trap_pkg::xlen-1:0]  ip_latched,
    output      logic [trap_pkg::xlen-1:0]  mie_reg,
    output      logic                       status_mie,
    output      logic [31:2]                mtvec,
    output      logic [31:1]                mepc,
    output      trap_pkg::priv_t            mpp
);
    logic                      mpie;
    logic                      mprv;
    logic [trap_pkg::xlen-1:0] mscratch;
    logic                      mcause_int;
    trap_pkg::cause_t          mcause_no;
    trap_pkg::csr_word_u       wr;
    trap_pkg::csr_word_u       status_word;

    // Write data seen as raw word and as mstatus.
    assign wr.raw = csr_wdata;

    // Trap and return take over any write in the same cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie <= 1'b0;
            mpie       <= 1'b0;
            mie_reg    <= '0;
            mtvec      <= '0;
            mscratch   <= '0;
            mepc       <= '0;
            mcause_int <= 1'b0;
            mcause_no  <= '0;
        end else if (ex_trap || ex_irq) begin
            mpie       <= status_mie;
            status_mie <= 1'b0;
            mepc       <= ex_epc;
            mcause_int <= ex_irq;
            mcause_no  <= ex_cause;
        end else if (ex_ret) begin
            status_mie <= mpie;
        end else if (csr_we) begin
            case (csr_addr)
                trap_pkg::csr_mstatus: begin
                    status_mie <= wr.status.mie;
                    mpie       <= wr.status.mpie;
                end
                trap_pkg::csr_mie:      mie_reg  <= csr_wdata;
                trap_pkg::csr_mtvec:    mtvec    <= csr_wdata[31:2];
                trap_pkg::csr_mscratch: mscratch <= csr_wdata;
                trap_pkg::csr_mepc:     mepc     <= csr_wdata[31:1];
                trap_pkg::csr_mcause: begin
                    mcause_int <= csr_wdata[31];
                    mcause_no  <= csr_wdata[4:0];
                end
                default: ;
            endcase
        end
    end

    // MPP and MPRV only move when U-mode exists.
    generate
        if (has_u_mode) begin : g_status_u
            always_ff @(posedge clk) begin
                if (rst) begin
                    mpp  <= trap_pkg::priv_m;
                    mprv <= 1'b0;
                end else if (ex_trap || ex_irq) begin
                    mpp <= cur_priv;
                end else if (ex_ret) begin
                    // Leaving M clears MPRV.
                    mprv <= mprv && (mpp == trap_pkg::priv_m);
                end else if (csr_we && csr_addr == trap_pkg::csr_mstatus) begin
                    mprv <= wr.status.mprv;
                    // Only M and U exist, so anything nonzero is M.
                    mpp  <= (wr.status.mpp != 2'd0) ? trap_pkg::priv_m : trap_pkg::priv_u;
                end
            end
        end else begin : g_status_m
            assign mpp  = trap_pkg::priv_m;
            assign mprv = 1'b0;
        end
    endgenerate

    // Assemble mstatus.
    always_comb begin
        status_word             = '0;
        status_word.status.mie  = status_mie;
        status_word.status.mpie = mpie;
        status_word.status.mpp  = mpp;
        status_word.status.mprv = mprv;
    end

    // Read mux with exists and read-only flags.
    always_comb begin
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        csr_rdata  = '0;
        case (csr_addr)
            trap_pkg::csr_mstatus:  csr_rdata = status_word.raw;
            trap_pkg::csr_misa:     csr_rdata = trap_pkg::misa_value;
            trap_pkg::csr_mie:      csr_rdata = mie_reg;
            trap_pkg::csr_mtvec:    csr_rdata = {mtvec, 2'b00};
            trap_pkg::csr_mip:      csr_rdata = ip_latched & mie_reg;
            trap_pkg::csr_mscratch: csr_rdata = mscratch;
            trap_pkg::csr_mepc:     csr_rdata = {mepc, 1'b0};
            trap_pkg::csr_mcause:   csr_rdata = {mcause_int, 26'd0, mcause_no};
            // Always zero.
            trap_pkg::csr_medeleg, trap_pkg::csr_mideleg,
            trap_pkg::csr_mstatush, trap_pkg::csr_mtval: csr_rdata = '0;
            trap_pkg::csr_mvendorid, trap_pkg::csr_mconfigptr: csr_rdonly = 1'b1;
            trap_pkg::csr_marchid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::marchid_value;
            end
            trap_pkg::csr_mimpid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = trap_pkg::mimpid_value;
            end
            trap_pkg::csr_mhartid: begin
                csr_rdonly = 1'b1;
                csr_rdata  = hartid;
            end
            default: csr_exists = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/trap_pkg.sv */
// Package trap_pkg: CSR addresses, privilege and cause types, CSR word union, fixed ID values.
`default_nettype none

package trap_pkg;

    // Data word width.
    localparam int xlen = 32;

    // CSR address.
    typedef logic [11:0] csr_addr_t;

    // Machine trap setup.
    localparam csr_addr_t csr_mstatus    = 12'h300;
    localparam csr_addr_t csr_misa       = 12'h301;
    localparam csr_addr_t csr_medeleg    = 12'h302;
    localparam csr_addr_t csr_mideleg    = 12'h303;
    localparam csr_addr_t csr_mie        = 12'h304;
    localparam csr_addr_t csr_mtvec      = 12'h305;
    localparam csr_addr_t csr_mstatush   = 12'h310;
    // Machine trap handling.
    localparam csr_addr_t csr_mscratch   = 12'h340;
    localparam csr_addr_t csr_mepc       = 12'h341;
    localparam csr_addr_t csr_mcause     = 12'h342;
    localparam csr_addr_t csr_mtval      = 12'h343;
    localparam csr_addr_t csr_mip        = 12'h344;
    // Machine information, read only.
    localparam csr_addr_t csr_mvendorid  = 12'hf11;
    localparam csr_addr_t csr_marchid    = 12'hf12;
    localparam csr_addr_t csr_mimpid     = 12'hf13;
    localparam csr_addr_t csr_mhartid    = 12'hf14;
    localparam csr_addr_t csr_mconfigptr = 12'hf15;

    // Privilege level.
    typedef logic [1:0] priv_t;
    localparam priv_t priv_u = 2'd0;
    localparam priv_t priv_m = 2'd3;

    // Trap or interrupt cause number.
    typedef logic [4:0] cause_t;
    // Timer interrupt.
    localparam cause_t irq_timer  = 5'd7;
    // First external line.
    localparam cause_t irq_ext_lo = 5'd16;

    // mstatus layout, no S-mode fields.
    typedef struct packed {
        logic [13:0] rsvd_31_18;
        logic        mprv;
        logic [3:0]  rsvd_16_13;
        priv_t       mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // One CSR word, seen raw or as mstatus.
    typedef union packed {
        logic [xlen-1:0] raw;
        mstatus_t        status;
    } csr_word_u;

    // RV32IM, MXL 1.
    localparam logic [xlen-1:0] misa_value    = 32'h4000_1100;
    // Architecture ID.
    localparam logic [xlen-1:0] marchid_value = 32'd37;
    // Version 2.0.0.
    localparam logic [xlen-1:0] mimpid_value  = 32'h0000_0200;

endpackage

`default_nettype wire
